/* design/gmii_pkg.sv */
// GMII interface definitions

package gmii_pkg;

    // link speed codes as reported on link_speed
    localparam logic [1:0] speed_10m   = 2'b00;
    localparam logic [1:0] speed_100m  = 2'b01;
    localparam logic [1:0] speed_1000m = 2'b10;

    // speed reported until the first measurement completes
    localparam logic [1:0] speed_reset = speed_1000m;

    // one lane is 8 data bits plus valid/enable and error
    localparam int gmii_lane_width = 10;

    // receive clock prescaler, top bit toggles every 4 receive clocks
    localparam int prescale_width = 3;

    // gtx_clk reference counter, overflow after 128 cycles means 10M
    localparam int ref_count_width = 7;

    // prescaler edge counter, saturates after 3 edges
    localparam int edge_count_width = 2;

    // synchronizer depth for the prescaler bit into gtx_clk
    localparam int sync_stages = 2;

    // reset synchronizer depth for the MAC-side clock domains
    localparam int rst_sync_stages = 4;

endpackage

/* design/gmii_speed_detect.sv */
// GMII link speed detector
`timescale 1ns/10ps

module gmii_speed_detect
    import gmii_pkg::*;
(
    input  logic       gtx_clk,
    input  logic       gtx_rst,
    input  logic       rx_clk,
    output logic [1:0] link_speed
);

    // receive clock domain prescaler, free running
    logic [prescale_width-1:0] rx_prescale = '0;

    // prescaler top bit moved into gtx_clk
    logic [sync_stages-1:0] prescale_sync;
    logic prescale_last;
    logic prescale_edge;

    // measurement counters
    logic [ref_count_width-1:0] ref_count;
    logic [edge_count_width-1:0] edge_count;
    logic ref_overflow;
    logic edge_saturated;
    logic ref_count_long;

    logic [1:0] link_speed_reg;

    always_ff @(posedge rx_clk) begin
        rx_prescale <= rx_prescale + prescale_width'(1);
    end

    // plain flip-flop chain, the prescaler bit is slow enough for it
    always_ff @(posedge gtx_clk) begin
        prescale_sync <= {prescale_sync[sync_stages-2:0], rx_prescale[prescale_width-1]};
        prescale_last <= prescale_sync[sync_stages-1];
    end

    // both edges of the prescaler bit count
    assign prescale_edge = prescale_sync[sync_stages-1] ^ prescale_last;

    assign ref_overflow   = &ref_count;
    assign edge_saturated = &edge_count;

    // top two bits nonzero means a reference count of 32 or more
    assign ref_count_long = |ref_count[ref_count_width-1 -: 2];

    always_ff @(posedge gtx_clk) begin
        if (gtx_rst) begin
            ref_count      <= '0;
            edge_count     <= '0;
            link_speed_reg <= speed_reset;
        end else if (edge_saturated) begin
            // three edges seen before overflow: 100M or 1000M
            ref_count  <= '0;
            edge_count <= '0;
            if (ref_count_long) begin
                link_speed_reg <= speed_100m;
            end else begin
                link_speed_reg <= speed_1000m;
            end
        end else if (ref_overflow) begin
            // receive clock too slow to reach three edges
            ref_count      <= '0;
            edge_count     <= '0;
            link_speed_reg <= speed_10m;
        end else begin
            ref_count <= ref_count + ref_count_width'(1);
            if (prescale_edge) begin
                edge_count <= edge_count + edge_count_width'(1);
            end
        end
    end

    assign link_speed = link_speed_reg;

endmodule

/* design/gmii_rx_path.sv */
// GMII receive path
`timescale 1ns/10ps

module gmii_rx_path
    import gmii_pkg::*;
(
    input  logic       gtx_rst,

    // PHY side
    input  logic       phy_gmii_rx_clk,
    input  logic [7:0] phy_gmii_rxd,
    input  logic       phy_gmii_rx_dv,
    input  logic       phy_gmii_rx_er,

    // MAC side
    output logic       mac_gmii_rx_clk,
    output logic       mac_gmii_rx_rst,
    output logic [7:0] mac_gmii_rxd,
    output logic       mac_gmii_rx_dv,
    output logic       mac_gmii_rx_er
);

    logic [gmii_lane_width-1:0] rx_lane_reg;
    logic [rst_sync_stages-1:0] rx_rst_sync;

    // the MAC receive domain runs on the PHY receive clock
    assign mac_gmii_rx_clk = phy_gmii_rx_clk;

    // input capture register, one receive clock of latency
    always_ff @(posedge mac_gmii_rx_clk) begin
        rx_lane_reg <= {phy_gmii_rxd, phy_gmii_rx_dv, phy_gmii_rx_er};
    end

    assign {mac_gmii_rxd, mac_gmii_rx_dv, mac_gmii_rx_er} = rx_lane_reg;

    // reset release walks through the chain on the receive clock
    always_ff @(posedge mac_gmii_rx_clk) begin
        if (gtx_rst) begin
            rx_rst_sync <= '1;
        end else begin
            rx_rst_sync <= {rx_rst_sync[rst_sync_stages-2:0], 1'b0};
        end
    end

    assign mac_gmii_rx_rst = rx_rst_sync[rst_sync_stages-1];

endmodule

/* design/gmii_tx_path.sv */
// GMII transmit path
`timescale 1ns/10ps

module gmii_tx_path
    import gmii_pkg::*;
(
    input  logic       gtx_clk,
    input  logic       gtx_rst,
    input  logic       phy_mii_tx_clk,
    input  logic [1:0] link_speed,

    // MAC side
    output logic       mac_gmii_tx_clk,
    output logic       mac_gmii_tx_rst,
    input  logic [7:0] mac_gmii_txd,
    input  logic       mac_gmii_tx_en,
    input  logic       mac_gmii_tx_er,

    // PHY side
    output logic       phy_gmii_tx_clk,
    output logic [7:0] phy_gmii_txd,
    output logic       phy_gmii_tx_en,
    output logic       phy_gmii_tx_er
);

    logic tx_clk_sel;
    logic [gmii_lane_width-1:0] tx_lane_reg;
    logic [rst_sync_stages-1:0] tx_rst_sync;

    // gtx_clk only at 1000M, the PHY supplies the MII clock below that
    assign tx_clk_sel = link_speed[1];

    // plain mux, stands in for a glitch-free clock buffer mux
    assign mac_gmii_tx_clk = tx_clk_sel ? gtx_clk : phy_mii_tx_clk;

    // transmit clock to the PHY, same edge as the lane register
    assign phy_gmii_tx_clk = mac_gmii_tx_clk;

    // output register for the transmit lane
    always_ff @(posedge mac_gmii_tx_clk) begin
        tx_lane_reg <= {mac_gmii_txd, mac_gmii_tx_en, mac_gmii_tx_er};
    end

    assign {phy_gmii_txd, phy_gmii_tx_en, phy_gmii_tx_er} = tx_lane_reg;

    // reset synchronizer for the selected transmit clock
    always_ff @(posedge mac_gmii_tx_clk) begin
        if (gtx_rst) begin
            tx_rst_sync <= '1;
        end else begin
            tx_rst_sync <= {tx_rst_sync[rst_sync_stages-2:0], 1'b0};
        end
    end

    assign mac_gmii_tx_rst = tx_rst_sync[rst_sync_stages-1];

endmodule

/* design/gmii_phy_if.sv */
// GMII PHY interface top
`timescale 1ns/10ps

module gmii_phy_if (
    input  logic       gtx_clk,
    input  logic       gtx_rst,

    // MAC side
    output logic       mac_gmii_rx_clk,
    output logic       mac_gmii_rx_rst,
    output logic [7:0] mac_gmii_rxd,
    output logic       mac_gmii_rx_dv,
    output logic       mac_gmii_rx_er,
    output logic       mac_gmii_tx_clk,
    output logic       mac_gmii_tx_rst,
    input  logic [7:0] mac_gmii_txd,
    input  logic       mac_gmii_tx_en,
    input  logic       mac_gmii_tx_er,

    // PHY side
    input  logic       phy_gmii_rx_clk,
    input  logic [7:0] phy_gmii_rxd,
    input  logic       phy_gmii_rx_dv,
    input  logic       phy_gmii_rx_er,
    input  logic       phy_mii_tx_clk,
    output logic       phy_gmii_tx_clk,
    output logic [7:0] phy_gmii_txd,
    output logic       phy_gmii_tx_en,
    output logic       phy_gmii_tx_er,

    // status
    output logic [1:0] link_speed
);

    // speed is measured on the forwarded receive clock
    gmii_speed_detect speed_detect0 (
        .gtx_clk    (gtx_clk),
        .gtx_rst    (gtx_rst),
        .rx_clk     (mac_gmii_rx_clk),
        .link_speed (link_speed)
    );

    gmii_rx_path rx_path0 (
        .gtx_rst         (gtx_rst),
        .phy_gmii_rx_clk (phy_gmii_rx_clk),
        .phy_gmii_rxd    (phy_gmii_rxd),
        .phy_gmii_rx_dv  (phy_gmii_rx_dv),
        .phy_gmii_rx_er  (phy_gmii_rx_er),
        .mac_gmii_rx_clk (mac_gmii_rx_clk),
        .mac_gmii_rx_rst (mac_gmii_rx_rst),
        .mac_gmii_rxd    (mac_gmii_rxd),
        .mac_gmii_rx_dv  (mac_gmii_rx_dv),
        .mac_gmii_rx_er  (mac_gmii_rx_er)
    );

    // transmit clock follows the detected speed
    gmii_tx_path tx_path0 (
        .gtx_clk         (gtx_clk),
        .gtx_rst         (gtx_rst),
        .phy_mii_tx_clk  (phy_mii_tx_clk),
        .link_speed      (link_speed),
        .mac_gmii_tx_clk (mac_gmii_tx_clk),
        .mac_gmii_tx_rst (mac_gmii_tx_rst),
        .mac_gmii_txd    (mac_gmii_txd),
        .mac_gmii_tx_en  (mac_gmii_tx_en),
        .mac_gmii_tx_er  (mac_gmii_tx_er),
        .phy_gmii_tx_clk (phy_gmii_tx_clk),
        .phy_gmii_txd    (phy_gmii_txd),
        .phy_gmii_tx_en  (phy_gmii_tx_en),
        .phy_gmii_tx_er  (phy_gmii_tx_er)
    );

endmodule

/* verif/gmii_phy_if_chk.sv */
// GMII speed and clock select assertions
`timescale 1ns/10ps

module gmii_phy_if_chk
    import gmii_pkg::*;
(
    input logic       gtx_clk,
    input logic       gtx_rst,
    input logic [1:0] link_speed,
    input logic       phy_mii_tx_clk,
    input logic       mac_gmii_tx_clk
);

    // 2'b11 is not a speed code
    a_speed_legal: assert property (
        @(posedge gtx_clk) disable iff (gtx_rst)
        link_speed != 2'b11
    ) else $error("link_speed holds the unused code %b", link_speed);

    // reset value shows one cycle after reset is sampled
    a_speed_reset: assert property (
        @(posedge gtx_clk)
        gtx_rst |=> link_speed == speed_reset
    ) else $error("link_speed is %b after reset, expected %b", link_speed, speed_reset);

    // upper speed bit set means the transmit clock is gtx_clk
    a_clk_sel_gtx: assert property (
        @(negedge gtx_clk) disable iff (gtx_rst)
        link_speed[1] |-> mac_gmii_tx_clk == gtx_clk
    ) else $error("mac_gmii_tx_clk is %b, gtx_clk is %b at link_speed %b",
                  mac_gmii_tx_clk, gtx_clk, link_speed);

    // upper speed bit clear means the PHY MII clock drives the transmit side
    a_clk_sel_mii: assert property (
        @(negedge gtx_clk) disable iff (gtx_rst)
        !link_speed[1] |-> mac_gmii_tx_clk == phy_mii_tx_clk
    ) else $error("mac_gmii_tx_clk is %b, phy_mii_tx_clk is %b at link_speed %b",
                  mac_gmii_tx_clk, phy_mii_tx_clk, link_speed);

endmodule

// the transmit path sees link_speed straight from the speed detector
bind gmii_tx_path gmii_phy_if_chk chk0 (
    .gtx_clk         (gtx_clk),
    .gtx_rst         (gtx_rst),
    .link_speed      (link_speed),
    .phy_mii_tx_clk  (phy_mii_tx_clk),
    .mac_gmii_tx_clk (mac_gmii_tx_clk)
);

/* verif/tb_gmii_phy_if.sv */
// GMII PHY interface testbench
`timescale 1ns/10ps

module tb_gmii_phy_if
    import gmii_pkg::*;
();

    // clock sources that the wait and compare tasks can follow
    localparam int src_gtx    = 0;
    localparam int src_rx     = 1;
    localparam int src_mii    = 2;
    localparam int src_mac_tx = 3;

    localparam int num_rows          = 4;
    localparam int speed_wait_cycles = 400;
    localparam int speed_hold_cycles = 300;
    localparam int lane_samples      = 8;

    // receive period and MII transmit period in ns, with the expected speed
    localparam int         row_rx_period  [num_rows] = '{8, 40, 400, 8};
    localparam int         row_mii_period [num_rows] = '{40, 40, 400, 40};
    localparam logic [1:0] row_speed      [num_rows] =
        '{speed_1000m, speed_100m, speed_10m, speed_1000m};

    int seed;
    int rx_half = row_rx_period[0] / 2;
    int mii_half = row_mii_period[0] / 2;

    logic       gtx_clk;
    logic       gtx_rst;
    logic       mac_gmii_rx_clk;
    logic       mac_gmii_rx_rst;
    logic [7:0] mac_gmii_rxd;
    logic       mac_gmii_rx_dv;
    logic       mac_gmii_rx_er;
    logic       mac_gmii_tx_clk;
    logic       mac_gmii_tx_rst;
    logic [7:0] mac_gmii_txd;
    logic       mac_gmii_tx_en;
    logic       mac_gmii_tx_er;
    logic       phy_gmii_rx_clk;
    logic [7:0] phy_gmii_rxd;
    logic       phy_gmii_rx_dv;
    logic       phy_gmii_rx_er;
    logic       phy_mii_tx_clk;
    logic       phy_gmii_tx_clk;
    logic [7:0] phy_gmii_txd;
    logic       phy_gmii_tx_en;
    logic       phy_gmii_tx_er;
    logic [1:0] link_speed;

    gmii_phy_if dut0 (
        .gtx_clk         (gtx_clk),
        .gtx_rst         (gtx_rst),
        .mac_gmii_rx_clk (mac_gmii_rx_clk),
        .mac_gmii_rx_rst (mac_gmii_rx_rst),
        .mac_gmii_rxd    (mac_gmii_rxd),
        .mac_gmii_rx_dv  (mac_gmii_rx_dv),
        .mac_gmii_rx_er  (mac_gmii_rx_er),
        .mac_gmii_tx_clk (mac_gmii_tx_clk),
        .mac_gmii_tx_rst (mac_gmii_tx_rst),
        .mac_gmii_txd    (mac_gmii_txd),
        .mac_gmii_tx_en  (mac_gmii_tx_en),
        .mac_gmii_tx_er  (mac_gmii_tx_er),
        .phy_gmii_rx_clk (phy_gmii_rx_clk),
        .phy_gmii_rxd    (phy_gmii_rxd),
        .phy_gmii_rx_dv  (phy_gmii_rx_dv),
        .phy_gmii_rx_er  (phy_gmii_rx_er),
        .phy_mii_tx_clk  (phy_mii_tx_clk),
        .phy_gmii_tx_clk (phy_gmii_tx_clk),
        .phy_gmii_txd    (phy_gmii_txd),
        .phy_gmii_tx_en  (phy_gmii_tx_en),
        .phy_gmii_tx_er  (phy_gmii_tx_er),
        .link_speed      (link_speed)
    );

    // 125 MHz reference, PHY clocks follow the current table row
    always #4 gtx_clk = ~gtx_clk;
    always #(rx_half) phy_gmii_rx_clk = ~phy_gmii_rx_clk;
    always #(mii_half) phy_mii_tx_clk = ~phy_mii_tx_clk;

    function automatic logic clock_level(input int src);
        case (src)
            src_gtx: return gtx_clk;
            src_rx:  return phy_gmii_rx_clk;
            src_mii: return phy_mii_tx_clk;
            default: return mac_gmii_tx_clk;
        endcase
    endfunction

    function automatic string clock_name(input int src);
        case (src)
            src_gtx: return "gtx_clk";
            src_rx:  return "phy_gmii_rx_clk";
            src_mii: return "phy_mii_tx_clk";
            default: return "mac_gmii_tx_clk";
        endcase
    endfunction

    function automatic logic [gmii_lane_width-1:0] random_lane();
        int r;
        r = $random(seed);
        return r[gmii_lane_width-1:0];
    endfunction

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("SIMULATION FAILED");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_speed(input string name, input logic [1:0] got, input logic [1:0] exp);
        if (got !== exp) begin
            fail_run($sformatf("Error: %s is %h, expected %h", name, got, exp));
        end
    endtask

    task automatic check_lane(input string name, input logic [gmii_lane_width-1:0] got,
                              input logic [gmii_lane_width-1:0] exp);
        if (got !== exp) begin
            fail_run($sformatf("Error: %s is %h, expected %h", name, got, exp));
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            fail_run($sformatf("Error: %s is %h, expected %h", name, got, exp));
        end
    endtask

    // all clock edges fall on whole ns, so polling at half ns is race free
    task automatic wait_rise(input int src, input int limit_ns);
        logic prev;
        logic level;
        int waited;
        #0.5;
        level = clock_level(src);
        prev = level;
        waited = 0;
        while (!(prev === 1'b0 && level === 1'b1)) begin
            if (waited >= limit_ns) begin
                fail_run($sformatf("Timed out waiting %0d ns for a rising edge on %s",
                                   limit_ns, clock_name(src)));
            end
            prev = level;
            #1;
            level = clock_level(src);
            waited++;
        end
        // return 1 ns after the edge, where inputs change
        #0.5;
    endtask

    task automatic check_reset_release(input int src);
        int edges;
        edges = 0;
        while ((src == src_rx ? mac_gmii_rx_rst : mac_gmii_tx_rst) !== 1'b0) begin
            if (edges >= rst_sync_stages + 1) begin
                fail_run($sformatf("Reset in the %s domain was not released after %0d edges",
                                   clock_name(src), edges));
            end
            wait_rise(src, 16);
            edges++;
        end
        if (edges < rst_sync_stages) begin
            fail_run($sformatf("Reset in the %s domain was released after only %0d edges",
                               clock_name(src), edges));
        end
    endtask

    task automatic wait_speed(input logic [1:0] exp);
        int cycles;
        cycles = 0;
        while (link_speed !== exp) begin
            if (cycles >= speed_wait_cycles) begin
                fail_run($sformatf("link_speed did not reach code %h within %0d gtx_clk cycles",
                                   exp, speed_wait_cycles));
            end
            wait_rise(src_gtx, 16);
            cycles++;
        end
    endtask

    task automatic hold_speed(input logic [1:0] exp);
        repeat (speed_hold_cycles) begin
            wait_rise(src_gtx, 16);
            check_speed("link_speed", link_speed, exp);
        end
    endtask

    // a lane driven after one receive edge shows up after the next one
    task automatic check_rx_lanes(input int limit_ns);
        logic [gmii_lane_width-1:0] sent;
        wait_rise(src_rx, limit_ns);
        sent = random_lane();
        {phy_gmii_rxd, phy_gmii_rx_dv, phy_gmii_rx_er} = sent;
        repeat (lane_samples) begin
            wait_rise(src_rx, limit_ns);
            check_lane("{mac_gmii_rxd, mac_gmii_rx_dv, mac_gmii_rx_er}",
                       {mac_gmii_rxd, mac_gmii_rx_dv, mac_gmii_rx_er}, sent);
            sent = random_lane();
            {phy_gmii_rxd, phy_gmii_rx_dv, phy_gmii_rx_er} = sent;
        end
    endtask

    // MAC and PHY clock outputs against their source clocks over two periods
    task automatic check_clock_outputs(input int src, input int period_ns);
        #0.5;
        repeat (2 * period_ns) begin
            check_bit("mac_gmii_tx_clk", mac_gmii_tx_clk, clock_level(src));
            check_bit("phy_gmii_tx_clk", phy_gmii_tx_clk, clock_level(src));
            check_bit("mac_gmii_rx_clk", mac_gmii_rx_clk, phy_gmii_rx_clk);
            #1;
        end
        #0.5;
    endtask

    task automatic check_tx_lanes(input int limit_ns);
        logic [gmii_lane_width-1:0] sent;
        wait_rise(src_mac_tx, limit_ns);
        sent = random_lane();
        {mac_gmii_txd, mac_gmii_tx_en, mac_gmii_tx_er} = sent;
        repeat (lane_samples) begin
            wait_rise(src_mac_tx, limit_ns);
            check_lane("{phy_gmii_txd, phy_gmii_tx_en, phy_gmii_tx_er}",
                       {phy_gmii_txd, phy_gmii_tx_en, phy_gmii_tx_er}, sent);
            sent = random_lane();
            {mac_gmii_txd, mac_gmii_tx_en, mac_gmii_tx_er} = sent;
        end
    endtask

    initial begin
        int row;
        int tx_src;
        int tx_period;
        seed = 32'h9e29_cb38;
        gtx_clk = 1'b0;
        gtx_rst = 1'b1;
        phy_gmii_rx_clk = 1'b0;
        phy_mii_tx_clk = 1'b0;
        phy_gmii_rxd = 8'h00;
        phy_gmii_rx_dv = 1'b0;
        phy_gmii_rx_er = 1'b0;
        mac_gmii_txd = 8'h00;
        mac_gmii_tx_en = 1'b0;
        mac_gmii_tx_er = 1'b0;

        repeat (3) begin
            wait_rise(src_gtx, 16);
        end
        gtx_rst = 1'b0;
        check_speed("link_speed", link_speed, speed_reset);
        check_bit("mac_gmii_rx_rst", mac_gmii_rx_rst, 1'b1);
        check_bit("mac_gmii_tx_rst", mac_gmii_tx_rst, 1'b1);

        // both MAC-side resets are released on their own clocks
        fork
            check_reset_release(src_rx);
            check_reset_release(src_mac_tx);
        join

        for (row = 0; row < num_rows; row++) begin
            rx_half = row_rx_period[row] / 2;
            mii_half = row_mii_period[row] / 2;
            wait_speed(row_speed[row]);
            hold_speed(row_speed[row]);
            check_rx_lanes(2 * row_rx_period[row] + 8);

            // gtx_clk drives the transmit side only at 1000M
            if (row_speed[row] == speed_1000m) begin
                tx_src = src_gtx;
                tx_period = 8;
            end else begin
                tx_src = src_mii;
                tx_period = row_mii_period[row];
            end
            check_clock_outputs(tx_src, tx_period);
            check_tx_lanes(2 * tx_period + 8);
        end

        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

/* sources.f */
design/gmii_pkg.sv
design/gmii_speed_detect.sv
design/gmii_rx_path.sv
design/gmii_tx_path.sv
design/gmii_phy_if.sv
verif/gmii_phy_if_chk.sv
verif/tb_gmii_phy_if.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the GMII PHY interface testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    --timescale 1ns/10ps \
    --top-module tb_gmii_phy_if \
    -f sources.f \
    -Mdir obj_dir \
    -o sim_tb_gmii_phy_if
build_status=$?
if [ "$build_status" -ne 0 ]; then
    echo "verilator build failed with status $build_status"
    exit "$build_status"
fi

./obj_dir/sim_tb_gmii_phy_if
run_status=$?
if [ "$run_status" -ne 0 ]; then
    echo "simulation exited with status $run_status"
    exit "$run_status"
fi

exit 0
